/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, and decide pass or fail from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
	--top-module rv_single_tb -f rv_single.f -o rv_single_sim

./obj_dir/rv_single_sim | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
	exit 0
else
	exit 1
fi

/* rv_alu.sv */
// **************************************************
// combinational alu, undefined op codes give zero
// **************************************************
`timescale 1ns/1ps
`default_nettype none
`include "rv_single_macros.svh"

module rv_alu (
	input  logic [`RV_XLEN-1:0]    srca,
	input  logic [`RV_XLEN-1:0]    srcb,
	input  rv_single_pkg::alu_op_e alu_op,
	output logic [`RV_XLEN-1:0]    result
);
	always_comb begin
		case (alu_op)
			rv_single_pkg::ALU_ADD:  result = srca + srcb;
			rv_single_pkg::ALU_SUB:  result = srca - srcb;
			rv_single_pkg::ALU_SLL:  result = srca << srcb[4:0]; // shamt low 5 bits
			rv_single_pkg::ALU_SLT:  result = {31'b0, $signed(srca) < $signed(srcb)};
			rv_single_pkg::ALU_SLTU: result = {31'b0, srca < srcb}; // sltiu too
			rv_single_pkg::ALU_XOR:  result = srca ^ srcb;
			rv_single_pkg::ALU_SRL:  result = srca >> srcb[4:0];
			rv_single_pkg::ALU_SRA:  result = $unsigned($signed(srca) >>> srcb[4:0]); // sign fill
			rv_single_pkg::ALU_OR:   result = srca | srcb;
			rv_single_pkg::ALU_AND:  result = srca & srcb;
			default:                 result = '0;
		endcase
	end
endmodule

`default_nettype wire

/* rv_controller.sv */
// **************************************************
// main and alu decode, fence/system decode as nop
// write enables held low while reset is high
// **************************************************
`timescale 1ns/1ps
`default_nettype none

module rv_controller (
	input  logic        reset,
	input  logic [31:0] instr,
	rv_ctrl_if.ctrl     ctl
);
	rv_single_pkg::opcode_e opcode;
	rv_single_pkg::alu_op_e alu_dec;
	logic [2:0]             funct3;
	logic                   f7_b5;
	logic                   mem_write_d;
	logic                   reg_write_d;

	assign opcode = rv_single_pkg::opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign f7_b5  = instr[30];

	// alu decoder, sub only for register ops
	always_comb begin
		case (funct3)
			3'b000:  alu_dec = (opcode == rv_single_pkg::OPC_OP && f7_b5) ?
				rv_single_pkg::ALU_SUB : rv_single_pkg::ALU_ADD;
			3'b001:  alu_dec = rv_single_pkg::ALU_SLL;
			3'b010:  alu_dec = rv_single_pkg::ALU_SLT;
			3'b011:  alu_dec = rv_single_pkg::ALU_SLTU;
			3'b100:  alu_dec = rv_single_pkg::ALU_XOR;
			3'b101:  alu_dec = f7_b5 ? rv_single_pkg::ALU_SRA : rv_single_pkg::ALU_SRL; // srai too
			3'b110:  alu_dec = rv_single_pkg::ALU_OR;
			default: alu_dec = rv_single_pkg::ALU_AND;
		endcase
	end

	// main decoder
	always_comb begin
		ctl.alu_op      = rv_single_pkg::ALU_ADD; // address adds by default
		ctl.alu_src_imm = 1'b0;
		ctl.is_store    = 1'b0;
		ctl.wb_src      = rv_single_pkg::WB_ALU;
		ctl.pc_sel      = rv_single_pkg::PC_PLUS4;
		mem_write_d     = 1'b0;
		reg_write_d     = 1'b0;
		case (opcode)
			rv_single_pkg::OPC_OP: begin
				ctl.alu_op  = alu_dec;
				reg_write_d = 1'b1;
			end
			rv_single_pkg::OPC_OP_IMM: begin
				ctl.alu_op      = alu_dec;
				ctl.alu_src_imm = 1'b1;
				reg_write_d     = 1'b1;
			end
			rv_single_pkg::OPC_LOAD: begin
				ctl.alu_src_imm = 1'b1;
				ctl.wb_src      = rv_single_pkg::WB_MEM;
				reg_write_d     = 1'b1;
			end
			rv_single_pkg::OPC_STORE: begin
				ctl.alu_src_imm = 1'b1;
				ctl.is_store    = 1'b1;
				mem_write_d     = 1'b1;
			end
			rv_single_pkg::OPC_BRANCH: // compare done in datapath
				ctl.pc_sel = ctl.br_taken ? rv_single_pkg::PC_BRANCH : rv_single_pkg::PC_PLUS4;
			rv_single_pkg::OPC_JAL: begin
				ctl.wb_src  = rv_single_pkg::WB_PC4; // link
				ctl.pc_sel  = rv_single_pkg::PC_JAL;
				reg_write_d = 1'b1;
			end
			rv_single_pkg::OPC_JALR: begin
				ctl.alu_src_imm = 1'b1; // rs1 + imm through alu
				ctl.wb_src      = rv_single_pkg::WB_PC4;
				ctl.pc_sel      = rv_single_pkg::PC_JALR;
				reg_write_d     = 1'b1;
			end
			rv_single_pkg::OPC_LUI: begin
				ctl.wb_src  = rv_single_pkg::WB_UIMM;
				reg_write_d = 1'b1;
			end
			rv_single_pkg::OPC_AUIPC: begin
				ctl.wb_src  = rv_single_pkg::WB_PCUIMM;
				reg_write_d = 1'b1;
			end
			default: ; // misc, system, unknown -> nop
		endcase
	end

	assign ctl.mem_write = mem_write_d & ~reset;
	assign ctl.reg_write = reg_write_d & ~reset;

endmodule

`default_nettype wire

/* rv_ctrl_if.sv */
// **************************************************
// decoded control, controller to datapath
// br_taken is the only signal flowing back
// **************************************************
`timescale 1ns/1ps
`default_nettype none

interface rv_ctrl_if;
	rv_single_pkg::alu_op_e alu_op;
	logic                   alu_src_imm; // srcb from immediate
	logic                   is_store;    // s-type imm select, not reset gated
	logic                   mem_write;
	logic                   reg_write;
	rv_single_pkg::wb_src_e wb_src;
	rv_single_pkg::pc_sel_e pc_sel;
	logic                   br_taken;    // branch compare result, funct3 only

	modport ctrl (
		output alu_op, alu_src_imm, is_store, mem_write, reg_write, wb_src, pc_sel,
		input  br_taken
	);

	modport dp (
		input  alu_op, alu_src_imm, is_store, mem_write, reg_write, wb_src, pc_sel,
		output br_taken
	);
endinterface

`default_nettype wire

/* rv_datapath.sv */
// **************************************************
// pc, immediates, operand and writeback muxes
// memories must answer in the same cycle
// **************************************************
`timescale 1ns/1ps
`default_nettype none
`include "rv_single_macros.svh"

module rv_datapath (
	input  logic                clk,
	input  logic                reset,
	input  logic [31:0]         instr,
	output logic [`RV_XLEN-1:0] pc,
	output logic [`RV_XLEN-1:0] dmem_addr,
	output logic [`RV_XLEN-1:0] dmem_wdata,
	input  logic [`RV_XLEN-1:0] dmem_rdata,
	rv_ctrl_if.dp               ctl
);
	`include "rv_datapath_functions.svh"

	logic [`RV_RADDR_W-1:0] rs1, rs2, rd;
	logic [2:0]             funct3;
	logic [`RV_XLEN-1:0]    imm_i, imm_s, imm_b, imm_j, imm_u;
	logic [`RV_XLEN-1:0]    imm_alu;
	logic [`RV_XLEN-1:0]    srca, rs2_data, srcb;
	logic [`RV_XLEN-1:0]    alu_result;
	logic [`RV_XLEN-1:0]    pc_plus4, pc_next;
	logic [`RV_XLEN-1:0]    load_val, wb_data;

	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign rd     = instr[11:7];
	assign funct3 = instr[14:12];

	// immediate forms
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
	assign imm_u = {instr[31:12], 12'b0}; // lui, auipc
	assign imm_alu = ctl.is_store ? imm_s : imm_i; // store address vs everything else

	assign pc_plus4 = pc + 32'd4;

	// next pc
	always_comb begin
		case (ctl.pc_sel)
			rv_single_pkg::PC_JAL:    pc_next = pc + imm_j;
			rv_single_pkg::PC_JALR:   pc_next = {alu_result[31:1], 1'b0}; // rs1+imm, bit 0 cleared
			rv_single_pkg::PC_BRANCH: pc_next = pc + imm_b;
			default:                  pc_next = pc_plus4;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			pc <= `RV_RESET_PC;
		else
			pc <= pc_next;
	end

	rv_regfile u_rf (
		.clk      (clk),
		.we       (ctl.reg_write),
		.rs1      (rs1),
		.rs2      (rs2),
		.rd       (rd),
		.wd       (wb_data),
		.rs1_data (srca),
		.rs2_data (rs2_data)
	);

	assign srcb = ctl.alu_src_imm ? imm_alu : rs2_data;

	rv_alu u_alu (
		.srca   (srca),
		.srcb   (srcb),
		.alu_op (ctl.alu_op),
		.result (alu_result)
	);

	// memory side, word address is dmem_addr[31:2]
	assign dmem_addr  = alu_result;
	assign dmem_wdata = store_merge(funct3, alu_result[1:0], dmem_rdata, rs2_data);
	assign load_val   = load_extract(funct3, alu_result[1:0], dmem_rdata);

	assign ctl.br_taken = br_cond(funct3, srca, rs2_data); // opcode gating in controller

	// writeback select
	always_comb begin
		case (ctl.wb_src)
			rv_single_pkg::WB_MEM:    wb_data = load_val;
			rv_single_pkg::WB_PC4:    wb_data = pc_plus4; // jal/jalr link
			rv_single_pkg::WB_UIMM:   wb_data = imm_u;
			rv_single_pkg::WB_PCUIMM: wb_data = pc + imm_u;
			default:                  wb_data = alu_result;
		endcase
	end

endmodule

`default_nettype wire

/* rv_datapath_functions.svh */
// **************************************************
// load, store and branch helpers for rv_datapath
// aligned accesses assumed, no misalign checks
// **************************************************

// pick byte or half from the read word, then extend
function automatic logic [31:0] load_extract(input logic [2:0] funct3,
		input logic [1:0] addr_lo, input logic [31:0] rdata);
	logic [31:0] sh;
	sh = rdata >> {addr_lo, 3'b000}; // lane down to bit 0
	case (funct3)
		3'b000:  return {{24{sh[7]}}, sh[7:0]};   // lb
		3'b001:  return {{16{sh[15]}}, sh[15:0]}; // lh
		3'b100:  return {24'b0, sh[7:0]};         // lbu
		3'b101:  return {16'b0, sh[15:0]};        // lhu
		default: return rdata;                    // lw
	endcase
endfunction

// read-modify-write of the addressed word
function automatic logic [31:0] store_merge(input logic [2:0] funct3,
		input logic [1:0] addr_lo, input logic [31:0] old_word, input logic [31:0] src);
	logic [31:0] w;
	w = old_word;
	case (funct3[1:0])
		2'b00:   w[addr_lo*8 +: 8] = src[7:0];        // sb
		2'b01:   w[addr_lo[1]*16 +: 16] = src[15:0];  // sh, upper or lower half
		default: w = src;                             // sw
	endcase
	return w;
endfunction

function automatic logic br_cond(input logic [2:0] funct3,
		input logic [31:0] a, input logic [31:0] b);
	case (funct3)
		3'b000:  return a == b;                   // beq
		3'b001:  return a != b;                   // bne
		3'b100:  return $signed(a) < $signed(b);  // blt
		3'b101:  return $signed(a) >= $signed(b); // bge
		3'b110:  return a < b;                    // bltu
		3'b111:  return a >= b;                   // bgeu
		default: return 1'b0;
	endcase
endfunction

/* rv_regfile.sv */
// **************************************************
// 2 read 1 write regfile, x0 reads zero
// reads combinational, write on rising edge
// **************************************************
`timescale 1ns/1ps
`default_nettype none
`include "rv_single_macros.svh"

module rv_regfile (
	input  logic                   clk,
	input  logic                   we,
	input  logic [`RV_RADDR_W-1:0] rs1,
	input  logic [`RV_RADDR_W-1:0] rs2,
	input  logic [`RV_RADDR_W-1:0] rd,
	input  logic [`RV_XLEN-1:0]    wd,
	output logic [`RV_XLEN-1:0]    rs1_data,
	output logic [`RV_XLEN-1:0]    rs2_data
);
	logic [`RV_XLEN-1:0] regs [0:`RV_NREGS-1];

	initial begin
		for (int i = 0; i < `RV_NREGS; i++)
			regs[i] = '0; // power-up zero
	end

	always_ff @(posedge clk)
		if (we && rd != '0) regs[rd] <= wd; // x0 writes dropped

	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];
endmodule

`default_nettype wire

/* rv_single.f */
+incdir+.
rv_single_pkg.sv
rv_ctrl_if.sv
rv_alu.sv
rv_regfile.sv
rv_controller.sv
rv_datapath.sv
rv_single_core.sv
rv_single_tb.sv

/* rv_single_core.sv */
// **************************************************
// rv32i single-cycle core, one instruction per clock
// imem/dmem combinational read, dmem word-wide write
// **************************************************
`timescale 1ns/1ps
`default_nettype none
`include "rv_single_macros.svh"

module rv_single_core (
	input  logic                clk,
	input  logic                reset,
	// instruction port
	output logic [`RV_XLEN-1:0] pc,
	input  logic [31:0]         instr,
	// data port, sub-word stores already merged
	output logic [`RV_XLEN-1:0] dmem_addr,
	output logic [`RV_XLEN-1:0] dmem_wdata,
	output logic                dmem_we,
	input  logic [`RV_XLEN-1:0] dmem_rdata
);
	rv_ctrl_if ctl_bus ();

	rv_controller u_ctrl (
		.reset (reset),
		.instr (instr),
		.ctl   (ctl_bus.ctrl)
	);

	rv_datapath u_dp (
		.clk        (clk),
		.reset      (reset),
		.instr      (instr),
		.pc         (pc),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_rdata (dmem_rdata),
		.ctl        (ctl_bus.dp)
	);

	assign dmem_we = ctl_bus.mem_write; // low during reset
endmodule

`default_nettype wire

/* rv_single_macros.svh */
// **************************************************
// core sizing, rv32i only, reset pc is the first fetch
// **************************************************
`ifndef RV_SINGLE_MACROS_SVH
`define RV_SINGLE_MACROS_SVH

`define RV_XLEN     32 // datapath width
`define RV_NREGS    32 // x0..x31
`define RV_RADDR_W  5  // regfile address bits
`define RV_RESET_PC 32'h0000_0000

`endif

/* rv_single_pkg.sv */
// **************************************************
// shared enums for the rv32i single-cycle core
// opcode values are the rv32i major opcodes
// **************************************************
`default_nettype none

package rv_single_pkg;

	// major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_MISC   = 7'b0001111 // fence, runs as nop
	} opcode_e;

	// {funct7[5], funct3} style coding
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SUB  = 4'b1000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_SRA  = 4'b1101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111
	} alu_op_e;

	typedef enum logic [2:0] {WB_ALU, WB_MEM, WB_PC4, WB_UIMM, WB_PCUIMM} wb_src_e;

	typedef enum logic [1:0] {PC_PLUS4, PC_JAL, PC_JALR, PC_BRANCH} pc_sel_e;

endpackage

`default_nettype wire

/* rv_single_tb.sv */
// **************************************************
// random 200-word program checked against an isa model
// x5 holds the data base, registers dumped to base+0x100
// **************************************************
`timescale 1ns/1ps
`default_nettype none
`include "rv_single_macros.svh"

module rv_single_tb;
	localparam int PERIOD  = 40;
	localparam int N_SETUP = 10;                    // reset-pc store, x5, then x1..x4
	localparam int N_BODY  = 157;                   // random part, after the setup words
	localparam int DUMP_W  = 32'h440;               // word index of 0x1100
	localparam int HALT_PC = (N_SETUP + N_BODY + 32) * 4; // self loop at the very end
	localparam int T_ALU = 0, T_PC = 1, T_LD = 2, T_ST = 3, T_UX0 = 4;

	logic        clk;
	logic        reset;
	logic [31:0] pc, instr, dmem_addr, dmem_wdata, dmem_rdata;
	logic        dmem_we;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:2047]; // written by the core
	logic [31:0] mdm  [0:2047]; // model copy
	logic [31:0] xr   [0:31];   // model registers
	int          last_kind [0:31]; // test owning each register's last write
	logic [31:0] mpc;
	int          errs [0:4];
	int          chks [0:4];
	string       names [0:4];

	rv_single_core u_dut (
		.clk        (clk),
		.reset      (reset),
		.pc         (pc),
		.instr      (instr),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.dmem_rdata (dmem_rdata)
	);

	// both memories answer in the same cycle
	assign instr      = imem[pc[9:2]];
	assign dmem_rdata = dmem[dmem_addr[12:2]];
	always @(posedge clk)
		if (dmem_we) dmem[dmem_addr[12:2]] <= dmem_wdata;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// 300 cycles is well past the longest straight run
	initial begin
		#((16 + 300) * PERIOD);
		$display("watchdog: core never reached the halt loop");
		$display("SIMULATION FAILED");
		$finish;
	end

	function automatic logic [31:0] r_word(input logic alt, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv_single_pkg::OPC_OP};
	endfunction

	function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_single_pkg::OPC_STORE};
	endfunction

	function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_single_pkg::OPC_BRANCH};
	endfunction

	function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_single_pkg::OPC_JAL};
	endfunction

	function automatic logic [4:0] pick_rd();
		logic [4:0] r;
		r = 5'($urandom);
		return (r == 5'd5) ? 5'd0 : r; // base kept, x0 gets extra writes
	endfunction

	task automatic gen_program();
		int          i, k, kind;
		logic [2:0]  f3;
		logic [11:0] imm;
		logic [4:0]  rd;
		for (i = 0; i < 256; i++)
			imem[i] = 32'h0000_0013; // nop
		imem[0] = s_word(12'h7fc, 5'd0, 5'd0, 3'b010); // store seen during reset, x0 to 0x7fc
		imem[1] = u_word(20'h00001, 5'd5, rv_single_pkg::OPC_LUI); // x5 = 0x1000
		for (i = 1; i <= 4; i++) begin
			imem[2*i]   = u_word(20'($urandom), 5'(i), rv_single_pkg::OPC_LUI);
			imem[2*i+1] = i_word(12'($urandom), 5'(i), 3'b000, 5'(i), rv_single_pkg::OPC_OP_IMM);
		end
		for (i = N_SETUP; i < N_SETUP + N_BODY; i++) begin
			rd   = pick_rd();
			k    = 2 + int'($urandom % 3); // forward skip, 2..4 words
			kind = int'($urandom % 10);
			if ((kind == 6 || kind == 7) && i + 4 > N_SETUP + N_BODY)
				kind = 0; // no jump past the dump
			f3  = 3'($urandom);
			imm = 12'($urandom % 256);
			case (kind)
				0, 1: imem[i] = r_word((f3 == 0 || f3 == 5) ? 1'($urandom) : 1'b0,
					5'($urandom), 5'($urandom), f3, rd);
				2, 3: begin
					imm = 12'($urandom);
					if (f3 == 3'd1) imm = {7'b0, imm[4:0]};                 // slli
					if (f3 == 3'd5) imm = {1'b0, imm[10], 5'b0, imm[4:0]};  // srli/srai
					imem[i] = i_word(imm, 5'($urandom), f3, rd, rv_single_pkg::OPC_OP_IMM);
				end
				4: begin
					f3 = 3'($urandom % 5);
					if (f3 >= 3'd3) f3 = f3 + 3'd1; // lb lh lw lbu lhu
					if (f3[1:0] == 2'd1) imm[0] = 1'b0;
					if (f3[1:0] == 2'd2) imm[1:0] = 2'b0;
					imem[i] = i_word(imm, 5'd5, f3, rd, rv_single_pkg::OPC_LOAD);
				end
				5: begin
					f3 = 3'($urandom % 3);
					if (f3 == 3'd1) imm[0] = 1'b0;
					if (f3 == 3'd2) imm[1:0] = 2'b0;
					imem[i] = s_word(imm, 5'($urandom), 5'd5, f3);
				end
				6: begin
					f3 = 3'($urandom % 6);
					if (f3 >= 3'd2) f3 = f3 + 3'd2; // skip the two reserved codes
					imem[i] = b_word(13'(4 * k), 5'($urandom), 5'($urandom), f3);
				end
				7: if ($urandom % 2)
					imem[i] = j_word(21'(4 * k), rd);
				else // odd target sometimes, bit 0 must drop
					imem[i] = i_word(12'(4 * (i + k) + int'($urandom % 2)), 5'd0, 3'b000, rd,
						rv_single_pkg::OPC_JALR);
				8: imem[i] = u_word(20'($urandom), rd,
					($urandom % 2) ? rv_single_pkg::OPC_LUI : rv_single_pkg::OPC_AUIPC);
				default: imem[i] = r_word(1'b0, 5'($urandom), 5'($urandom), f3, 5'd0); // x0 write
			endcase
		end
		for (i = 0; i < 32; i++)
			imem[N_SETUP + N_BODY + i] = s_word(12'(256 + 4 * i), 5'(i), 5'd5, 3'b010); // dump
		imem[N_SETUP + N_BODY + 32] = j_word(21'd0, 5'd0); // halt
	endtask

	function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		logic signed [31:0] sa;
		logic [31:0]        r;
		sa = a;
		case (f3)
			3'd0:    r = alt ? a - b : a + b;
			3'd1:    r = a << b[4:0];
			3'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3:    r = (a < b) ? 32'd1 : 32'd0;
			3'd4:    r = a ^ b;
			3'd5:
				if (alt)
					r = sa >>> b[4:0];
				else
					r = a >> b[4:0];
			3'd6:    r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	task automatic flag_mismatch(input int t, input string what, input logic [31:0] exp,
			input logic [31:0] act);
		$display("Fail %s %s: expected %h actual %h", names[t], what, exp, act);
		errs[t]++;
	endtask

	task automatic log_problem(input int t, input string msg);
		$display("Error in %s: %s", names[t], msg);
		errs[t]++;
	endtask

	// checks the current cycle, then advances the model one instruction
	task automatic step_model();
		logic [31:0] ins, a, b, ia, addr, w, nxt, res, mask;
		logic [4:0]  rd;
		logic [2:0]  f3;
		logic        wr, tk;
		int          kind;
		ins  = imem[mpc[9:2]];
		f3   = ins[14:12];
		rd   = ins[11:7];
		a    = xr[ins[19:15]];
		b    = xr[ins[24:20]];
		ia   = {{20{ins[31]}}, ins[31:20]};
		nxt  = mpc + 32'd4;
		res  = 32'h0;
		wr   = 1'b1;
		kind = T_ALU;
		chks[T_PC]++;
		if (pc !== mpc) flag_mismatch(T_PC, "pc", mpc, pc);
		if (ins[6:0] != rv_single_pkg::OPC_STORE) begin
			chks[T_ST]++;
			if (dmem_we !== 1'b0) log_problem(T_ST, "dmem_we high on a non-store instruction");
		end
		case (ins[6:0])
			rv_single_pkg::OPC_OP:     res = alu_model(f3, ins[30], a, b);
			rv_single_pkg::OPC_OP_IMM: res = alu_model(f3, ins[30] && f3 == 3'd5, a, ia);
			rv_single_pkg::OPC_LOAD: begin
				addr = a + ia;
				w    = mdm[addr[12:2]] >> (8 * addr[1:0]); // lane to bit 0
				case (f3)
					3'b000:  res = {{24{w[7]}}, w[7:0]};
					3'b001:  res = {{16{w[15]}}, w[15:0]};
					3'b100:  res = {24'h0, w[7:0]};
					3'b101:  res = {16'h0, w[15:0]};
					default: res = w;
				endcase
				kind = T_LD;
			end
			rv_single_pkg::OPC_STORE: begin
				addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
				mask = (f3[1:0] == 2'd0) ? 32'h0000_00ff :
					(f3[1:0] == 2'd1) ? 32'h0000_ffff : 32'hffff_ffff;
				mask = mask << (8 * addr[1:0]);
				w    = (mdm[addr[12:2]] & ~mask) | ((b << (8 * addr[1:0])) & mask);
				chks[T_ST]++;
				if (dmem_we !== 1'b1) begin
					log_problem(T_ST, "dmem_we stayed low on a store");
				end else begin
					if (dmem_addr !== addr) flag_mismatch(T_ST, "dmem_addr", addr, dmem_addr);
					if (dmem_wdata !== w) flag_mismatch(T_ST, "dmem_wdata", w, dmem_wdata);
				end
				mdm[addr[12:2]] = w;
				wr = 1'b0;
			end
			rv_single_pkg::OPC_BRANCH: begin
				case (f3)
					3'b000:  tk = (a == b);
					3'b001:  tk = (a != b);
					3'b100:  tk = ($signed(a) < $signed(b));
					3'b101:  tk = !($signed(a) < $signed(b));
					3'b110:  tk = (a < b);
					default: tk = !(a < b);
				endcase
				if (tk) nxt = mpc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
				wr = 1'b0;
			end
			rv_single_pkg::OPC_JAL: begin
				res  = mpc + 32'd4; // link
				nxt  = mpc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
				kind = T_PC;
			end
			rv_single_pkg::OPC_JALR: begin
				res  = mpc + 32'd4;
				nxt  = (a + ia) & ~32'h1;
				kind = T_PC;
			end
			rv_single_pkg::OPC_LUI: begin
				res  = {ins[31:12], 12'h0};
				kind = T_UX0;
			end
			rv_single_pkg::OPC_AUIPC: begin
				res  = mpc + {ins[31:12], 12'h0};
				kind = T_UX0;
			end
			default: wr = 1'b0;
		endcase
		if (wr && rd != 5'd0) begin
			xr[rd]        = res;
			last_kind[rd] = kind;
		end
		mpc = nxt;
	endtask

	initial begin
		int seed_ret;
		int i;
		int total;
		int nchk;
		seed_ret = $urandom(70621);
		names[T_ALU] = "alu_imm_ops";
		names[T_PC]  = "pc_flow";
		names[T_LD]  = "loads";
		names[T_ST]  = "stores";
		names[T_UX0] = "upper_imm_x0";
		for (i = 0; i < 5; i++) begin
			errs[i] = 0;
			chks[i] = 0;
		end
		for (i = 0; i < 2048; i++) begin
			dmem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f; // preset data, per address
			mdm[i]  = dmem[i];
		end
		for (i = 0; i < 32; i++) begin
			xr[i]        = 32'h0;
			last_kind[i] = T_ALU;
		end
		last_kind[0] = T_UX0;
		gen_program();
		mpc   = `RV_RESET_PC;
		reset = 1'b1;
		repeat (16) begin
			@(negedge clk);
			chks[T_UX0]++;
			if (pc !== `RV_RESET_PC) flag_mismatch(T_UX0, "pc in reset", `RV_RESET_PC, pc);
			if (dmem_we !== 1'b0) log_problem(T_UX0, "dmem_we high during reset");
		end
		reset = 1'b0;
		while (mpc != HALT_PC) begin
			#(PERIOD / 4); // settled, well before the rising edge
			step_model();
			@(negedge clk);
		end
		chks[T_PC]++;
		if (pc !== mpc) flag_mismatch(T_PC, "halt pc", mpc, pc);
		// dump words written by the core, charged to the test that last wrote each register
		for (i = 0; i < 32; i++) begin
			chks[last_kind[i]]++;
			if (dmem[DUMP_W + i] !== xr[i])
				flag_mismatch(last_kind[i], $sformatf("x%0d", i), xr[i], dmem[DUMP_W + i]);
		end
		total = 0;
		nchk  = 0;
		for (i = 0; i < 5; i++) begin
			$display("test %-12s %0d checks, %0d errors, %s", names[i], chks[i], errs[i],
				(errs[i] == 0) ? "ok" : "bad");
			total += errs[i];
			nchk  += chks[i];
		end
		$display("5 tests, %0d checks, %0d errors", nchk, total);
		if (total == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end
endmodule

`default_nettype wire
